/* run_sim.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=execute_stage_tb
BUILD_DIR=obj_dir
LOG=sim.log

echo "building ${TOP}"
verilator --binary --timing --assert -f verilog.f --top-module "${TOP}" \
	--Mdir "${BUILD_DIR}" -o "${TOP}_sim"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

echo "running simulation"
"./${BUILD_DIR}/${TOP}_sim" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
	echo "simulation exited with status ${status}"
	exit 1
fi

if grep -qx "Test OK" "${LOG}"; then
	echo "simulation passed"
	exit 0
fi
echo "pass message not found in ${LOG}"
exit 1

/* source/add_sub_unit.sv */
/*
 * add/sub functional unit
 * add, subtract and BEQ/BNE/BLT resolution, holds one result until granted
 */

`timescale 1ns/100ps
`default_nettype none

module add_sub_unit import ooo_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          valid_in,
	input  logic          yumi,
	input  issue_packet_t issue,
	output logic          ready,
	output logic          valid_out,
	output cdb_packet_t   out
);

	logic [XLEN-1:0] sum;
	logic zero;
	logic negative;
	logic overflow;
	logic sub;
	logic taken;
	cdb_packet_t res_d;
	cdb_packet_t res_q;

	assign sub = (issue.op != OP_ADD); // branches compare via subtract

	ripple_adder u_adder (
		.rs1      (issue.rs1),
		.rs2      (issue.rs2),
		.sub      (sub),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow)
	);

	always_comb begin
		case (issue.op)
			OP_BEQ:  taken = zero;
			OP_BNE:  taken = ~zero;
			OP_BLT:  taken = negative ^ overflow; // signed less-than
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		res_d.dest_rob_entry = issue.rob_tag;
		res_d.result = sum;
		res_d.branch_result = taken;
		res_d.from_memory = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_out <= 1'b0;
		end else if (valid_in) begin
			valid_out <= 1'b1;
		end else if (yumi) begin
			valid_out <= 1'b0; // broadcast this cycle
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in) begin
			res_q <= res_d;
		end
	end

	assign ready = ~valid_out; // single entry
	assign out = res_q;

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
/*
 * round-robin CDB arbiter
 * grants one waiting unit per cycle and drives its packet on the bus
 */

`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter import ooo_pkg::*; #(
	parameter int NUM_PORTS = NUM_FU
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_PORTS-1:0] req,
	input  cdb_packet_t          fu_out [NUM_PORTS],
	output logic [NUM_PORTS-1:0] yumi,
	output logic                 cdb_valid,
	output cdb_packet_t          cdb
);

	localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	logic [PTR_W-1:0] ptr; // highest priority port this cycle
	logic [PTR_W-1:0] win;
	logic found;

	always_comb begin
		int cand;

		found = 1'b0;
		win = '0;
		yumi = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			cand = (int'(ptr) + i) % NUM_PORTS;
			if (!found && req[cand]) begin
				found = 1'b1;
				win = PTR_W'(cand);
			end
		end
		yumi[win] = found;
	end

	assign cdb_valid = found;
	assign cdb = fu_out[win];

	// start after the last winner
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (found) begin
			if (win == PTR_W'(NUM_PORTS - 1))
				ptr <= '0;
			else
				ptr <= win + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
/*
 * integer execute stage
 * router, add/sub and logic units sharing one CDB through the arbiter
 */

`timescale 1ns/100ps
`default_nettype none

module execute_stage import ooo_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          issue_valid,
	input  issue_packet_t issue,
	output logic          issue_ready,
	output logic          cdb_valid,
	output cdb_packet_t   cdb
);

	logic add_valid;
	logic logic_valid;
	logic add_ready;
	logic logic_ready;
	logic [NUM_FU-1:0] fu_valid;
	logic [NUM_FU-1:0] fu_yumi;
	cdb_packet_t fu_out [NUM_FU];

	issue_router u_router (
		.issue_valid (issue_valid),
		.issue       (issue),
		.add_ready   (add_ready),
		.logic_ready (logic_ready),
		.add_valid   (add_valid),
		.logic_valid (logic_valid),
		.issue_ready (issue_ready)
	);

	add_sub_unit u_add ( // CDB port 0
		.clk       (clk),
		.rst_n     (rst_n),
		.valid_in  (add_valid),
		.yumi      (fu_yumi[0]),
		.issue     (issue),
		.ready     (add_ready),
		.valid_out (fu_valid[0]),
		.out       (fu_out[0])
	);

	logic_unit u_logic ( // CDB port 1
		.clk       (clk),
		.rst_n     (rst_n),
		.valid_in  (logic_valid),
		.yumi      (fu_yumi[1]),
		.issue     (issue),
		.ready     (logic_ready),
		.valid_out (fu_valid[1]),
		.out       (fu_out[1])
	);

	cdb_arbiter #(
		.NUM_PORTS (NUM_FU)
	) u_arb (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (fu_valid),
		.fu_out    (fu_out),
		.yumi      (fu_yumi),
		.cdb_valid (cdb_valid),
		.cdb       (cdb)
	);

endmodule

`default_nettype wire

/* source/issue_router.sv */
/*
 * issue router
 * steers each issue packet to the unit for its op class
 */

`timescale 1ns/100ps
`default_nettype none

module issue_router import ooo_pkg::*; (
	input  logic          issue_valid,
	input  issue_packet_t issue,
	input  logic          add_ready,
	input  logic          logic_ready,
	output logic          add_valid,
	output logic          logic_valid,
	output logic          issue_ready
);

	logic add_class;

	assign add_class = is_add_class(issue.op);

	// ready follows only the unit that would take this op
	assign issue_ready = add_class ? add_ready : logic_ready;

	assign add_valid = issue_valid & add_class & add_ready;
	assign logic_valid = issue_valid & ~add_class & logic_ready;

endmodule

`default_nettype wire

/* source/logic_unit.sv */
/*
 * logic functional unit
 * AND/OR/XOR and logical shifts, holds one result until granted
 */

`timescale 1ns/100ps
`default_nettype none

module logic_unit import ooo_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          valid_in,
	input  logic          yumi,
	input  issue_packet_t issue,
	output logic          ready,
	output logic          valid_out,
	output cdb_packet_t   out
);

	logic [XLEN-1:0] result;
	logic [4:0] shamt;
	cdb_packet_t res_d;
	cdb_packet_t res_q;

	assign shamt = issue.rs2[4:0];

	always_comb begin
		case (issue.op)
			OP_AND:  result = issue.rs1 & issue.rs2;
			OP_OR:   result = issue.rs1 | issue.rs2;
			OP_XOR:  result = issue.rs1 ^ issue.rs2;
			OP_SLL:  result = issue.rs1 << shamt;
			OP_SRL:  result = issue.rs1 >> shamt; // zero fill
			default: result = '0;
		endcase
	end

	always_comb begin
		res_d.dest_rob_entry = issue.rob_tag;
		res_d.result = result;
		res_d.branch_result = 1'b0;
		res_d.from_memory = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_out <= 1'b0;
		end else if (valid_in) begin
			valid_out <= 1'b1;
		end else if (yumi) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in) begin
			res_q <= res_d;
		end
	end

	assign ready = ~valid_out;
	assign out = res_q;

endmodule

`default_nettype wire

/* source/ooo_pkg.sv */
/*
 * execute stage shared types
 * op codes, tag width, issue and CDB packet layouts
 */

`default_nettype none

package ooo_pkg;

	localparam int ROB_TAG_W = 4;
	localparam int XLEN = 32;
	localparam int NUM_FU = 2; // units sharing the CDB

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_BEQ = 4'd2,
		OP_BNE = 4'd3,
		OP_BLT = 4'd4,
		OP_AND = 4'd5,
		OP_OR  = 4'd6,
		OP_XOR = 4'd7,
		OP_SLL = 4'd8,
		OP_SRL = 4'd9
	} alu_op_t;

	// 72 bits, from the reservation stations
	typedef struct packed {
		alu_op_t op;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		logic [ROB_TAG_W-1:0] rob_tag;
	} issue_packet_t;

	// 38 bits, broadcast to ROB and stations
	typedef struct packed {
		logic [ROB_TAG_W-1:0] dest_rob_entry;
		logic [XLEN-1:0] result;
		logic branch_result; // taken
		logic from_memory;
	} cdb_packet_t;

	// add/sub unit handles arithmetic and branch compares
	function automatic logic is_add_class(alu_op_t op);
		return op inside {OP_ADD, OP_SUB, OP_BEQ, OP_BNE, OP_BLT};
	endfunction

endpackage

`default_nettype wire

/* source/ripple_adder.sv */
/*
 * ripple-carry adder/subtractor
 * sum plus zero, negative and overflow flags
 */

`timescale 1ns/100ps
`default_nettype none

module ripple_adder import ooo_pkg::*; (
	input  logic [XLEN-1:0] rs1,
	input  logic [XLEN-1:0] rs2,
	input  logic            sub,
	output logic [XLEN-1:0] sum,
	output logic            zero,
	output logic            negative,
	output logic            overflow
);

	logic [XLEN-1:0] b;
	logic [XLEN:0]   carry;
	logic [XLEN/4-1:0] nib_or;

	assign b = rs2 ^ {XLEN{sub}}; // two's complement with carry-in
	assign carry[0] = sub;

	genvar i;
	generate
		for (i = 0; i < XLEN; i++) begin : g_fa
			logic p; // propagate

			assign p = rs1[i] ^ b[i];
			assign sum[i] = p ^ carry[i];
			assign carry[i+1] = (rs1[i] & b[i]) | (p & carry[i]);
		end
	endgenerate

	// first level of the zero tree, one OR per nibble
	genvar g;
	generate
		for (g = 0; g < XLEN/4; g++) begin : g_zero
			assign nib_or[g] = |sum[4*g +: 4];
		end
	endgenerate

	assign zero = ~|nib_or;
	assign negative = sum[XLEN-1];
	assign overflow = carry[XLEN] ^ carry[XLEN-1]; // carry into vs out of sign

endmodule

`default_nettype wire

/* testbench/execute_stage_tb.sv */
/*
 * execute stage testbench
 * reference model and scoreboard by ROB tag, checked by assertions
 */

`timescale 1ns/100ps
`default_nettype none

module execute_stage_tb import ooo_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_DIRECTED = 24;
	localparam int NUM_RANDOM = 200;
	localparam int OP_BOUND = 4; // stall, accept and idle cycles per op
	localparam int TIMEOUT_NS =
		(RESET_CYCLES + (NUM_DIRECTED + NUM_RANDOM) * OP_BOUND + 40) * CLK_PERIOD;
	localparam int NUM_TAGS = 1 << ROB_TAG_W;

	logic clk;
	logic rst_n;
	logic issue_valid;
	issue_packet_t issue;
	logic issue_ready;
	logic cdb_valid;
	cdb_packet_t cdb;

	// scoreboard with one slot per tag
	logic [NUM_TAGS-1:0] exp_valid;
	logic [NUM_TAGS-1:0] exp_add;
	cdb_packet_t exp_pkt [NUM_TAGS];
	logic add_busy;
	logic logic_busy;
	logic last_add; // add/sub unit won the last broadcast
	logic [NUM_FU-1:0] grant_exp;
	logic ready_exp;

	execute_stage dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.cdb_valid   (cdb_valid),
		.cdb         (cdb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_failed();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("ERR %s got %h expected %h", name, got, exp);
		stop_failed();
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	function automatic logic uses_adder(input alu_op_t op);
		return (op == OP_ADD) || (op == OP_SUB) || (op == OP_BEQ) ||
			(op == OP_BNE) || (op == OP_BLT);
	endfunction

	function automatic cdb_packet_t expected_packet(input issue_packet_t p);
		cdb_packet_t e;

		e.dest_rob_entry = p.rob_tag;
		e.branch_result = 1'b0;
		e.from_memory = 1'b0;
		case (p.op)
			OP_ADD:  e.result = p.rs1 + p.rs2;
			OP_AND:  e.result = p.rs1 & p.rs2;
			OP_OR:   e.result = p.rs1 | p.rs2;
			OP_XOR:  e.result = p.rs1 ^ p.rs2;
			OP_SLL:  e.result = p.rs1 << p.rs2[4:0];
			OP_SRL:  e.result = p.rs1 >> p.rs2[4:0];
			default: e.result = p.rs1 - p.rs2; // sub and branches
		endcase
		case (p.op)
			OP_BEQ:  e.branch_result = (p.rs1 == p.rs2);
			OP_BNE:  e.branch_result = (p.rs1 != p.rs2);
			OP_BLT:  e.branch_result = ($signed(p.rs1) < $signed(p.rs2));
			default: ;
		endcase
		return e;
	endfunction

	function automatic logic [ROB_TAG_W-1:0] free_tag();
		logic [ROB_TAG_W-1:0] t;

		t = ROB_TAG_W'($urandom);
		for (int i = 0; i < NUM_TAGS; i++) begin
			if (!exp_valid[t])
				return t;
			t = t + 1'b1;
		end
		return t;
	endfunction

	// offer one op from a falling edge and hold it until taken
	task automatic issue_op(input alu_op_t op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		issue_packet_t p;

		p.op = op;
		p.rs1 = a;
		p.rs2 = b;
		p.rob_tag = free_tag();
		issue = p;
		issue_valid = 1'b1;
		#1;
		while (!issue_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		issue_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	assign ready_exp = uses_adder(issue.op) ? !add_busy : !logic_busy;

	// round robin over the units the model holds busy
	always_comb begin
		if (add_busy && logic_busy)
			grant_exp = last_add ? 2'b10 : 2'b01;
		else
			grant_exp = {logic_busy, add_busy};
	end

	// scoreboard and unit occupancy
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_valid <= '0;
			add_busy <= 1'b0;
			logic_busy <= 1'b0;
			last_add <= 1'b0; // port 0 wins the first tie
		end else begin
			if (cdb_valid) begin
				exp_valid[cdb.dest_rob_entry] <= 1'b0;
				if (exp_add[cdb.dest_rob_entry])
					add_busy <= 1'b0;
				else
					logic_busy <= 1'b0;
				last_add <= exp_add[cdb.dest_rob_entry];
			end
			if (issue_valid && issue_ready) begin
				exp_valid[issue.rob_tag] <= 1'b1;
				exp_add[issue.rob_tag] <= uses_adder(issue.op);
				exp_pkt[issue.rob_tag] <= expected_packet(issue);
				if (uses_adder(issue.op))
					add_busy <= 1'b1;
				else
					logic_busy <= 1'b1;
			end
		end
	end

	a_cdb_known: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> exp_valid[cdb.dest_rob_entry])
		else report_failure("CDB broadcast carries a tag that is not in flight");

	a_cdb_packet: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> (cdb == exp_pkt[cdb.dest_rob_entry]))
		else report_mismatch("cdb", 64'($sampled(cdb)),
			64'(exp_pkt[$sampled(cdb.dest_rob_entry)]));

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(dut.fu_yumi))
		else report_failure("more than one unit granted the CDB in one cycle");

	a_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
		((dut.fu_yumi & ~dut.fu_valid) == '0) && (cdb_valid == |dut.fu_valid))
		else report_failure("CDB grant does not match the waiting units");

	// a lone waiting unit wins at once and two waiting units take turns
	a_alternate: assert property (@(posedge clk) disable iff (!rst_n)
		dut.fu_yumi == grant_exp)
		else report_mismatch("fu_yumi", 64'($sampled(dut.fu_yumi)),
			64'($sampled(grant_exp)));

	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		issue_ready == ready_exp)
		else report_mismatch("issue_ready", 64'($sampled(issue_ready)),
			64'($sampled(ready_exp)));

	initial begin
		#(TIMEOUT_NS);
		report_failure("timeout, the execute stage stopped accepting or broadcasting");
	end

	initial begin
		alu_op_t op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;

		void'($urandom(99));
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		repeat (2) begin // idle after reset
			@(negedge clk);
			#1;
			assert (!cdb_valid)
				else report_mismatch("cdb_valid", 64'(cdb_valid), 64'(0));
			assert (issue_ready)
				else report_mismatch("issue_ready", 64'(issue_ready), 64'(1));
		end
		@(negedge clk);

		// add and subtract corners
		issue_op(OP_ADD, 32'h0000_0001, 32'h0000_0002);
		issue_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
		issue_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001); // zero result
		issue_op(OP_ADD, 32'h8000_0000, 32'h8000_0000);
		issue_op(OP_SUB, 32'h0000_0005, 32'h0000_0005);
		issue_op(OP_SUB, 32'h8000_0000, 32'h0000_0001);
		issue_op(OP_SUB, 32'h0000_0000, 32'h0000_0001);
		issue_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);

		// branch compares
		issue_op(OP_BEQ, 32'h0000_1234, 32'h0000_1234);
		issue_op(OP_BEQ, 32'h0000_0001, 32'h0000_0002);
		issue_op(OP_BNE, 32'h0000_1234, 32'h0000_1234);
		issue_op(OP_BNE, 32'h0000_0000, 32'hffff_ffff);
		issue_op(OP_BLT, 32'hffff_ffff, 32'h0000_0001);
		issue_op(OP_BLT, 32'h0000_0001, 32'hffff_ffff);
		issue_op(OP_BLT, 32'h8000_0000, 32'h7fff_ffff); // difference overflows
		issue_op(OP_BLT, 32'h7fff_ffff, 32'h8000_0000);
		issue_op(OP_BLT, 32'h0000_0005, 32'h0000_0005);

		// logic and shifts
		issue_op(OP_AND, 32'hf0f0_ff00, 32'h3c3c_0ff0);
		issue_op(OP_OR,  32'hf0f0_ff00, 32'h3c3c_0ff0);
		issue_op(OP_XOR, 32'hf0f0_ff00, 32'h3c3c_0ff0);
		issue_op(OP_SLL, 32'ha5a5_a5a5, 32'h0000_0024); // amount 4
		issue_op(OP_SLL, 32'h0000_0001, 32'h0000_001f);
		issue_op(OP_SRL, 32'h8000_0000, 32'h0000_001f);
		issue_op(OP_SRL, 32'hffff_ffff, 32'hffff_ffe0);

		// interleaved traffic where back to back ops stall on the busy unit
		for (int n = 0; n < NUM_RANDOM; n++) begin
			op = alu_op_t'(4'($urandom_range(9, 0)));
			a = $urandom;
			b = ($urandom_range(3, 0) == 0) ? a : $urandom;
			issue_op(op, a, b);
			if ($urandom_range(4, 0) == 0)
				idle_cycles(1);
		end

		issue_valid = 1'b0;
		while ($countones(exp_valid) != 0) @(negedge clk);
		@(negedge clk);
		#1;
		assert (!cdb_valid)
			else report_mismatch("cdb_valid", 64'(cdb_valid), 64'(0));

		if ($countones(exp_valid) == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			report_failure("scoreboard still holds results at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
source/ooo_pkg.sv
source/ripple_adder.sv
source/add_sub_unit.sv
source/logic_unit.sv
source/issue_router.sv
source/cdb_arbiter.sv
source/execute_stage.sv
testbench/execute_stage_tb.sv
